// ==== verilog/dcachePkg.sv ====
//####################################################################
// Shared types and defaults for the two-way write-back data cache.
// Import into module bodies; use scoped names in module headers.
//####################################################################
package dcachePkg;

    // Data word or byte address
    typedef logic [31:0] wordT;

    // One enable bit per byte lane
    typedef logic [3:0] byteMaskT;

    // Default geometry passed down from the top level
    parameter int blockWords = 4;
    parameter int numSets = 2;

    // Miss handling sequence
    //   idle      hits served, misses and bypass accesses start here
    //   writeBack dirty victim goes out to the bus, one word per beat
    //   fill      block comes in from the bus, one word per beat
    //   bypass    single uncached beat
    //   done      refilled line answers the waiting access
    typedef enum logic [2:0] {
        idle,
        writeBack,
        fill,
        bypass,
        done
    } cacheStateT;

endpackage

// ==== verilog/wayPortIf.sv ====
//####################################################################
// Way access bundle between the cache controller, the datapath and
// the tag/data storage. One instance per cache, set up at the top.
//####################################################################
interface wayPortIf #(
    parameter int numSets = dcachePkg::numSets,
    parameter int blockWords = dcachePkg::blockWords
);
    import dcachePkg::*;

    localparam int setBits = $clog2(numSets);
    localparam int offBits = $clog2(blockWords);
    localparam int tagBits = 30 - setBits - offBits;

    // Addressing, shared by both ways
    logic [setBits-1:0] setIdx;
    logic [offBits-1:0] wordOff;
    logic [tagBits-1:0] wrTag;

    // Per-way write enables and write values
    logic [1:0] dataWe;
    logic [1:0] tagWe;
    logic [1:0] dirtyWe;
    logic validIn;
    logic dirtyIn;
    wordT wrWord;

    // Read-back of both ways at setIdx / wordOff
    logic [tagBits-1:0] tagOut [2];
    logic [1:0] validOut;
    logic [1:0] dirtyOut;
    wordT wordOut [2];

    // Replacement and bulk invalidate
    logic lruWay;
    logic [1:0] touch;
    logic invAll;

    modport mem (
        input setIdx, wordOff, wrTag, dataWe, tagWe, dirtyWe,
        input validIn, dirtyIn, wrWord, touch, invAll,
        output tagOut, validOut, dirtyOut, wordOut, lruWay
    );

    modport ctrl (
        output dataWe, tagWe, dirtyWe, validIn, dirtyIn, touch, invAll,
        input wrTag, tagOut, validOut, dirtyOut, lruWay
    );

    modport dp (
        output setIdx, wordOff, wrTag, wrWord,
        input wordOut, tagOut
    );

endinterface

// ==== verilog/cacheMemory.sv ====
//####################################################################
// Tag, status and data storage for both ways, plus one LRU bit per
// set. Combinational read, clocked write; driven through wayPortIf.
//####################################################################
module cacheMemory #(
    parameter int numSets = dcachePkg::numSets,
    parameter int blockWords = dcachePkg::blockWords
) (
    input  logic clk,
    input  logic reset,
    wayPortIf.mem way
);
    import dcachePkg::*;

    localparam int setBits = $clog2(numSets);
    localparam int offBits = $clog2(blockWords);
    localparam int tagBits = 30 - setBits - offBits;

    // Block data and tags
    wordT dataMem [2][numSets][blockWords];
    logic [tagBits-1:0] tagMem [2][numSets];

    // Status bits cleared on reset
    logic [numSets-1:0] validMem [2];
    logic [numSets-1:0] dirtyMem [2];

    // Bit holds the least recently used way of each set
    logic [numSets-1:0] lruMem;

    // Read ports
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way.wordOut[w] = dataMem[w][way.setIdx][way.wordOff];
            way.tagOut[w] = tagMem[w][way.setIdx];
            way.validOut[w] = validMem[w][way.setIdx];
            way.dirtyOut[w] = dirtyMem[w][way.setIdx];
        end
    end

    assign way.lruWay = lruMem[way.setIdx];

    // Word writes from hits and fill beats
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (way.dataWe[w]) begin
                dataMem[w][way.setIdx][way.wordOff] <= way.wrWord;
            end
        end
    end

    // Tag writes go with the valid bit
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (way.tagWe[w]) begin
                tagMem[w][way.setIdx] <= way.wrTag;
            end
        end
    end

    // Valid and dirty
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < 2; w++) begin
                validMem[w] <= '0;
                dirtyMem[w] <= '0;
            end
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (way.invAll) begin
                    // Whole cache dropped along with any dirty data
                    validMem[w] <= '0;
                    dirtyMem[w] <= '0;
                end else begin
                    if (way.tagWe[w]) begin
                        validMem[w][way.setIdx] <= way.validIn;
                    end
                    if (way.dirtyWe[w]) begin
                        dirtyMem[w][way.setIdx] <= way.dirtyIn;
                    end
                end
            end
        end
    end

    // On a touch the other way becomes the victim
    always_ff @(posedge clk) begin
        if (reset) begin
            lruMem <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (way.touch[w]) begin
                    lruMem[way.setIdx] <= (w == 0);
                end
            end
        end
    end

endmodule

// ==== verilog/cacheController.sv ====
//####################################################################
// Cache control FSM: hit detection, write-back and fill sequencing,
// uncached bypass beats, LRU touch and the invalidate-all strobe.
//####################################################################
module cacheController #(
    parameter int blockWords = dcachePkg::blockWords
) (
    input  logic clk,
    input  logic reset,
    input  logic MemWriteM,
    input  logic MemtoRegM,
    input  logic Cacheable,
    input  logic InvAll,
    input  logic BusReady,
    output logic Stall,
    output logic HRequestM,
    output logic HWriteM,
    output logic hitWay,
    output logic useVictimTag,
    output logic fillBeat,
    output logic [$clog2(blockWords)-1:0] beatOffset,
    wayPortIf.ctrl way
);
    import dcachePkg::*;

    localparam int offBits = $clog2(blockWords);
    localparam logic [offBits-1:0] lastBeat = offBits'(blockWords - 1);

    cacheStateT state;
    cacheStateT nextState;

    logic [offBits-1:0] beatCount;
    logic access;
    logic hit0;
    logic hit1;
    logic hit;
    logic victimDirty;
    logic beatDone;
    logic hitAccess;

    assign access = MemWriteM | MemtoRegM;

    // Tag compare on both ways at once
    assign hit0 = way.validOut[0] && (way.tagOut[0] == way.wrTag);
    assign hit1 = way.validOut[1] && (way.tagOut[1] == way.wrTag);
    assign hit = hit0 | hit1;

    assign victimDirty = way.validOut[way.lruWay] & way.dirtyOut[way.lruWay];
    assign beatDone = BusReady && (beatCount == lastBeat);
    assign beatOffset = beatCount;

    // Hits are served in idle and in the cycle after a refill
    assign hitAccess = access && Cacheable && hit && (state == idle || state == done);

    // Miss states work on the victim way and all others on the hitting way
    assign hitWay = (state == writeBack || state == fill) ? way.lruWay : hit1;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= nextState;
        end
    end

    // Beat counter wraps at the end of each block transfer
    always_ff @(posedge clk) begin
        if (reset || state == idle) begin
            beatCount <= '0;
        end else if (BusReady && (state == writeBack || state == fill)) begin
            beatCount <= beatCount + 1'b1;
        end
    end

    always_comb begin
        nextState = state;
        Stall = 1'b0;
        HRequestM = 1'b0;
        HWriteM = 1'b0;
        useVictimTag = 1'b0;
        fillBeat = 1'b0;
        way.dataWe = '0;
        way.tagWe = '0;
        way.dirtyWe = '0;
        way.validIn = 1'b0;
        way.dirtyIn = 1'b0;
        way.touch = '0;
        way.invAll = (state == idle) && InvAll;

        case (state)
            idle: begin
                if (access && !Cacheable) begin
                    Stall = 1'b1;
                    nextState = bypass;
                end else if (access && !hit) begin
                    Stall = 1'b1;
                    nextState = victimDirty ? writeBack : fill;
                end
            end
            writeBack: begin
                Stall = 1'b1;
                HRequestM = 1'b1;
                HWriteM = 1'b1;
                useVictimTag = 1'b1;
                if (beatDone) begin
                    nextState = fill;
                end
            end
            fill: begin
                Stall = 1'b1;
                HRequestM = 1'b1;
                fillBeat = 1'b1;
                // Returning words land in the victim way and leave the line clean
                way.dataWe[way.lruWay] = BusReady;
                way.tagWe[way.lruWay] = BusReady;
                way.dirtyWe[way.lruWay] = BusReady;
                way.validIn = 1'b1;
                if (beatDone) begin
                    nextState = done;
                end
            end
            bypass: begin
                HRequestM = 1'b1;
                HWriteM = MemWriteM;
                Stall = !BusReady;
                if (BusReady) begin
                    nextState = idle;
                end
            end
            done: begin
                nextState = idle;
            end
            default: begin
                nextState = idle;
            end
        endcase

        if (hitAccess) begin
            way.touch[hit1] = 1'b1;
            if (MemWriteM) begin
                way.dataWe[hit1] = 1'b1;
                way.dirtyWe[hit1] = 1'b1;
                way.dirtyIn = 1'b1;
            end
        end
    end

endmodule

// ==== verilog/cacheDatapath.sv ====
//####################################################################
// Cache datapath: address split, byte merge of write data, read-data
// select and bus address/data formation for bus beats.
//####################################################################
module cacheDatapath #(
    parameter int numSets = dcachePkg::numSets,
    parameter int blockWords = dcachePkg::blockWords
) (
    input  dcachePkg::wordT VirtA,
    input  dcachePkg::wordT WD,
    input  dcachePkg::byteMaskT ByteMaskM,
    input  dcachePkg::wordT HRData,
    input  logic MemWriteM,
    input  logic hitWay,
    input  logic useVictimTag,
    input  logic fillBeat,
    input  logic [$clog2(blockWords)-1:0] beatOffset,
    input  logic Cacheable,
    output dcachePkg::wordT RD,
    output dcachePkg::wordT HAddr,
    output dcachePkg::wordT HWData,
    wayPortIf.dp way
);
    import dcachePkg::*;

    localparam int setBits = $clog2(numSets);
    localparam int offBits = $clog2(blockWords);
    localparam int tagBits = 30 - setBits - offBits;

    logic [tagBits-1:0] reqTag;
    logic [tagBits-1:0] busTag;
    logic [setBits-1:0] reqSet;
    logic [offBits-1:0] reqOffset;
    logic mergeEn;
    wordT storedWord;
    wordT baseWord;

    // Address fields
    assign reqOffset = VirtA[offBits+1:2];
    assign reqSet = VirtA[offBits+2 +: setBits];
    assign reqTag = VirtA[31 -: tagBits];

    assign way.setIdx = reqSet;
    assign way.wrTag = reqTag;
    // Bus beats walk the block, otherwise the requested word
    assign way.wordOff = (useVictimTag || fillBeat) ? beatOffset : reqOffset;

    assign storedWord = way.wordOut[hitWay];
    assign baseWord = fillBeat ? HRData : storedWord;

    // During a fill only the requested word takes the store data
    assign mergeEn = MemWriteM && (!fillBeat || beatOffset == reqOffset);

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            if (mergeEn && ByteMaskM[b]) begin
                way.wrWord[8*b +: 8] = WD[8*b +: 8];
            end else begin
                way.wrWord[8*b +: 8] = baseWord[8*b +: 8];
            end
        end
    end

    // Uncached reads come straight off the bus
    assign RD = Cacheable ? storedWord : HRData;

    // Victim tag while writing back, request tag while filling
    assign busTag = useVictimTag ? way.tagOut[hitWay] : reqTag;
    assign HAddr = Cacheable ? {busTag, reqSet, way.wordOff, 2'b00} : VirtA;
    assign HWData = Cacheable ? storedWord : WD;

endmodule

// ==== verilog/dataCache.sv ====
//####################################################################
// Two-way set-associative write-back data cache, top level.
// Processor memory-stage ports on one side, word-wide bus on the other.
//####################################################################
module dataCache #(
    parameter int numSets = dcachePkg::numSets,
    parameter int blockWords = dcachePkg::blockWords
) (
    input  logic clk,
    input  logic reset,
    // Processor side
    input  logic MemWriteM,
    input  logic MemtoRegM,
    input  logic Cacheable,
    input  logic InvAll,
    input  dcachePkg::wordT VirtA,
    input  dcachePkg::wordT WD,
    input  dcachePkg::byteMaskT ByteMaskM,
    output dcachePkg::wordT RD,
    output logic Stall,
    // Bus side
    input  logic BusReady,
    input  dcachePkg::wordT HRData,
    output logic HRequestM,
    output logic HWriteM,
    output dcachePkg::wordT HAddr,
    output dcachePkg::wordT HWData
);
    localparam int offBits = $clog2(blockWords);

    logic hitWay;
    logic useVictimTag;
    logic fillBeat;
    logic [offBits-1:0] beatOffset;

    wayPortIf #(.numSets(numSets), .blockWords(blockWords)) way ();

    cacheMemory #(.numSets(numSets), .blockWords(blockWords)) mem (
        .clk(clk),
        .reset(reset),
        .way(way)
    );

    cacheController #(.blockWords(blockWords)) ctrl (
        .clk(clk),
        .reset(reset),
        .MemWriteM(MemWriteM),
        .MemtoRegM(MemtoRegM),
        .Cacheable(Cacheable),
        .InvAll(InvAll),
        .BusReady(BusReady),
        .Stall(Stall),
        .HRequestM(HRequestM),
        .HWriteM(HWriteM),
        .hitWay(hitWay),
        .useVictimTag(useVictimTag),
        .fillBeat(fillBeat),
        .beatOffset(beatOffset),
        .way(way)
    );

    cacheDatapath #(.numSets(numSets), .blockWords(blockWords)) dp (
        .VirtA(VirtA),
        .WD(WD),
        .ByteMaskM(ByteMaskM),
        .HRData(HRData),
        .MemWriteM(MemWriteM),
        .hitWay(hitWay),
        .useVictimTag(useVictimTag),
        .fillBeat(fillBeat),
        .beatOffset(beatOffset),
        .Cacheable(Cacheable),
        .RD(RD),
        .HAddr(HAddr),
        .HWData(HWData),
        .way(way)
    );

endmodule

// ==== test/dataCacheTb.sv ====
//####################################################################
// Testbench for the data cache. Runs a step table against a bus
// memory model with random wait states and a reference memory array.
//####################################################################
module dataCacheTb;
    import dcachePkg::*;

    localparam int clkPeriod = 10;
    localparam int memWords = 256;
    localparam int maxWait = 2;
    // Idle cycle, write-back and fill at worst-case waits, done cycle, slack
    localparam int missCycles = 2 * blockWords * (maxWait + 1) + 3;

    localparam logic [1:0] opRead = 2'd0;
    localparam logic [1:0] opWrite = 2'd1;
    localparam logic [1:0] opInv = 2'd2;
    localparam logic [1:0] opMemChk = 2'd3;

    typedef struct packed {
        logic [1:0] op;
        logic cacheable;
        wordT addr;
        wordT data;
        byteMaskT mask;
        logic expStall;
    } stepT;

    logic clk;
    logic reset;
    logic MemWriteM;
    logic MemtoRegM;
    logic Cacheable;
    logic InvAll;
    wordT VirtA;
    wordT WD;
    byteMaskT ByteMaskM;
    wordT RD;
    logic Stall;
    logic BusReady = 1'b0;
    wordT HRData = '0;
    logic HRequestM;
    logic HWriteM;
    wordT HAddr;
    wordT HWData;

    wordT busMem [memWords];
    wordT refMem [memWords];
    stepT steps [$];
    integer seed = 12176;
    int waitLeft;
    logic beatArmed;

    dataCache #(.numSets(numSets), .blockWords(blockWords)) DUT (
        .clk(clk),
        .reset(reset),
        .MemWriteM(MemWriteM),
        .MemtoRegM(MemtoRegM),
        .Cacheable(Cacheable),
        .InvAll(InvAll),
        .VirtA(VirtA),
        .WD(WD),
        .ByteMaskM(ByteMaskM),
        .RD(RD),
        .Stall(Stall),
        .BusReady(BusReady),
        .HRData(HRData),
        .HRequestM(HRequestM),
        .HWriteM(HWriteM),
        .HAddr(HAddr),
        .HWData(HWData)
    );

    initial clk = 1'b0;
    always #(clkPeriod / 2) clk = ~clk;

    // Pattern depends on every address bit, so aliasing shows up
    function automatic wordT fillPattern(input int idx);
        wordT addr;
        addr = wordT'(idx) << 2;
        return (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic wordT applyMask(input wordT old, input wordT data, input byteMaskT mask);
        wordT laneBits;
        laneBits = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
        return (old & ~laneBits) | (data & laneBits);
    endfunction

    task automatic checkValue(input string name, input wordT got, input wordT expected);
        if (got !== expected) begin
            $display("Fail at time %0t: %s is 0x%h, expected 0x%h", $time, name, got, expected);
            $display("FAIL: see errors above");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Bus memory model answers each beat after 0 to maxWait cycles
    always @(negedge clk) begin
        if (reset || HRequestM !== 1'b1) begin
            BusReady <= 1'b0;
            beatArmed = 1'b0;
        end else begin
            if (!beatArmed) begin
                waitLeft = $unsigned($random(seed)) % (maxWait + 1);
                beatArmed = 1'b1;
            end
            if (waitLeft == 0) begin
                BusReady <= 1'b1;
                HRData <= busMem[HAddr[9:2]];
                beatArmed = 1'b0;
            end else begin
                BusReady <= 1'b0;
                waitLeft = waitLeft - 1;
            end
        end
    end

    // Pattern loaded while in reset
    // Write beats land on the completing edge
    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < memWords; i++) begin
                busMem[i] = fillPattern(i);
            end
        end else if (HRequestM === 1'b1 && BusReady && HWriteM) begin
            busMem[HAddr[9:2]] = HWData;
        end
    end

    task automatic addStep(input logic [1:0] op, input logic cacheable, input wordT addr,
                           input wordT data, input byteMaskT mask, input logic expStall);
        steps.push_back(stepT'{op, cacheable, addr, data, mask, expStall});
    endtask

    task automatic buildSteps();
        // Set 0 holds blocks 0x040 (A), 0x080 (B), 0x0C0 (C)
        addStep(opRead, 1'b1, 32'h044, 32'h0, 4'hF, 1'b1);
        addStep(opRead, 1'b1, 32'h048, 32'h0, 4'hF, 1'b0);
        addStep(opWrite, 1'b1, 32'h04C, 32'h1122_3344, 4'hF, 1'b0);
        addStep(opRead, 1'b1, 32'h084, 32'h0, 4'hF, 1'b1);
        addStep(opWrite, 1'b1, 32'h088, 32'hDEAD_BEEF, 4'h3, 1'b0);
        // C evicts dirty A
        addStep(opRead, 1'b1, 32'h0C0, 32'h0, 4'hF, 1'b1);
        addStep(opMemChk, 1'b1, 32'h040, 32'h0, 4'h0, 1'b0);
        addStep(opRead, 1'b1, 32'h08C, 32'h0, 4'hF, 1'b0);
        addStep(opRead, 1'b1, 32'h04C, 32'h0, 4'hF, 1'b1);
        // Dirty B goes out and the partial mask keeps the upper bytes
        addStep(opRead, 1'b1, 32'h0C4, 32'h0, 4'hF, 1'b1);
        addStep(opMemChk, 1'b1, 32'h080, 32'h0, 4'h0, 1'b0);
        // Uncached traffic
        addStep(opWrite, 1'b0, 32'h200, 32'hCAFE_F00D, 4'hF, 1'b1);
        addStep(opMemChk, 1'b0, 32'h200, 32'h0, 4'h0, 1'b0);
        addStep(opRead, 1'b0, 32'h200, 32'h0, 4'hF, 1'b1);
        addStep(opRead, 1'b0, 32'h0C8, 32'h0, 4'hF, 1'b1);
        addStep(opRead, 1'b1, 32'h0C8, 32'h0, 4'hF, 1'b0);
        addStep(opRead, 1'b1, 32'h044, 32'h0, 4'hF, 1'b0);
        // Write-allocate in set 1 with a partial mask
        addStep(opWrite, 1'b1, 32'h014, 32'hA1B2_C3D4, 4'hC, 1'b1);
        addStep(opRead, 1'b1, 32'h014, 32'h0, 4'hF, 1'b0);
        addStep(opRead, 1'b1, 32'h034, 32'h0, 4'hF, 1'b1);
        addStep(opRead, 1'b1, 32'h054, 32'h0, 4'hF, 1'b1);
        addStep(opMemChk, 1'b1, 32'h010, 32'h0, 4'h0, 1'b0);
        // Earlier hits miss again after invalidate all
        addStep(opInv, 1'b1, 32'h0, 32'h0, 4'h0, 1'b0);
        addStep(opRead, 1'b1, 32'h044, 32'h0, 4'hF, 1'b1);
        addStep(opRead, 1'b1, 32'h054, 32'h0, 4'hF, 1'b1);
        addStep(opRead, 1'b1, 32'h048, 32'h0, 4'hF, 1'b0);
    endtask

    task automatic runStep(input stepT s, input int num);
        int wordIdx;
        wordIdx = int'(s.addr[9:2]);
        @(negedge clk);
        MemWriteM <= (s.op == opWrite);
        MemtoRegM <= (s.op == opRead);
        InvAll <= (s.op == opInv);
        Cacheable <= s.cacheable;
        VirtA <= s.addr;
        WD <= s.data;
        ByteMaskM <= s.mask;
        // Outputs settle just after the falling edge
        #1;
        checkValue($sformatf("Stall (step %0d, first cycle)", num), 32'(Stall),
                   32'(s.expStall));
        // Held until the access completes
        while (Stall) begin
            @(negedge clk);
            #1;
        end
        if (s.op == opRead) begin
            checkValue($sformatf("RD (step %0d)", num), RD, refMem[wordIdx]);
        end else if (s.op == opWrite) begin
            refMem[wordIdx] = applyMask(refMem[wordIdx], s.data, s.mask);
        end else if (s.op == opMemChk) begin
            for (int w = 0; w < blockWords; w++) begin
                checkValue($sformatf("busMem[0x%h]", (wordIdx + w) * 4),
                           busMem[wordIdx + w], refMem[wordIdx + w]);
            end
        end
    endtask

    initial begin
        reset <= 1'b1;
        MemWriteM <= 1'b0;
        MemtoRegM <= 1'b0;
        Cacheable <= 1'b0;
        InvAll <= 1'b0;
        VirtA <= '0;
        WD <= '0;
        ByteMaskM <= '0;
        for (int i = 0; i < memWords; i++) begin
            refMem[i] = fillPattern(i);
        end
        buildSteps();
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset <= 1'b0;
        #1;
        checkValue("Stall after reset", 32'(Stall), 32'd0);
        checkValue("HRequestM after reset", 32'(HRequestM), 32'd0);
        checkValue("HWriteM after reset", 32'(HWriteM), 32'd0);
        for (int i = 0; i < steps.size(); i++) begin
            runStep(steps[i], i);
        end
        $display("PASS: all tests");
        $finish;
    end

    // Watchdog sized from the step count and the worst-case miss
    initial begin
        int limit;
        #1;
        limit = (steps.size() * missCycles + 8) * clkPeriod;
        #(limit);
        $display("Timeout after %0d time units, an access never completed", limit);
        $display("FAIL: see errors above");
        $fatal(1, "watchdog timeout");
    end

endmodule

// ==== vlog.f ====
verilog/dcachePkg.sv
verilog/wayPortIf.sv
verilog/cacheMemory.sv
verilog/cacheController.sv
verilog/cacheDatapath.sv
verilog/dataCache.sv
test/dataCacheTb.sv

// ==== run.sh ====
#!/bin/sh
# Compile the data cache testbench with Verilator and run it.
# The result is taken from the simulation log.

buildDir=obj_dir
logFile=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module dataCacheTb \
    -Mdir "$buildDir" -o dataCacheTb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$buildDir/dataCacheTb" > "$logFile" 2>&1
status=$?
cat "$logFile"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^PASS: all tests$" "$logFile"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
